// ==== files.f ====
+incdir+.
lbm_pkg.sv
lattice_ram.sv
sweep_decoder.sv
stream_bounce_engine.sv
moment_result.sv
lbm_lattice_top.sv
lbm_properties.sv
lbm_checker.sv
lbm_tb.sv

// ==== lattice_ram.sv ====
`default_nettype none

module lattice_ram
    import lbm_pkg::*;
(
    input  wire logic                    clk,
    input  wire logic [$bits(cell_t):0] rd_addr,
    output pop_t                         rd_data,
    input  wire logic                    wr_en,
    input  wire logic [$bits(cell_t):0] wr_addr,
    input  wire pop_t                    wr_data
);

    localparam int depth = 2 ** ($bits(cell_t) + 1);

    // upper address bit picks the bank, lower bits the cell
    pop_t mem [depth];

    always_ff @(posedge clk)
    begin
        if (wr_en)
        begin
            mem[wr_addr] <= wr_data;
        end
    end

    // registered read, old data on a same-address write
    always_ff @(posedge clk)
    begin
        rd_data <= mem[rd_addr];
    end

endmodule

`default_nettype wire

// ==== lbm_checker.sv ====
`include "lbm_settings.svh"

`default_nettype none

module lbm_checker
    import lbm_pkg::*;
(
    input  wire logic     clk,
    input  wire logic     rst,
    input  wire logic     dump_valid,
    input  wire cell_t    dump_cell,
    input  wire pop_vec_t dump_pops,
    input  wire rho_t     dump_rho,
    input  wire logic     step_done,
    input  wire pop_vec_t exp_state [`LBM_GRID_W * `LBM_GRID_H],
    output int            value_errors,
    output int            order_errors,
    output int            steps_seen
);

    timeunit 1ns;
    timeprecision 100ps;

    localparam int n_cells = `LBM_GRID_W * `LBM_GRID_H;

    // beats seen in the current step, also the expected cell
    int beat;

    always @(posedge clk)
    begin : watch_dump
        rho_t exp_rho;
        int   bad_value;
        int   bad_order;
        if (rst)
        begin
            beat         <= 0;
            value_errors <= 0;
            order_errors <= 0;
            steps_seen   <= 0;
        end
        else
        begin
            bad_value = 0;
            bad_order = 0;
            if (dump_valid && beat >= n_cells)
            begin
                $display("dump beat %0d arrived after the last cell of the step", beat);
                bad_order++;
            end
            else if (dump_valid)
            begin
                if (dump_cell != cell_t'(beat))
                begin
                    $display("** Error at %0d ns: beat %0d carries cell %0d", $time, beat,
                             dump_cell);
                    bad_order++;
                end
                exp_rho = '0;
                for (int d = 0; d < `LBM_N_DIR; d++)
                begin
                    exp_rho = exp_rho + rho_t'(exp_state[beat][d]);
                    if (dump_pops[d] != exp_state[beat][d])
                    begin
                        $display("** Error at %0d ns: cell %0d dir %0d got %0d expected %0d",
                                 $time, beat, d, dump_pops[d], exp_state[beat][d]);
                        bad_value++;
                    end
                end
                if (dump_rho != exp_rho)
                begin
                    $display("** Error at %0d ns: cell %0d rho got %0d expected %0d",
                             $time, beat, dump_rho, exp_rho);
                    bad_value++;
                end
            end
            if (dump_valid)
            begin
                beat <= beat + 1;
            end
            if (step_done)
            begin
                if (beat != n_cells)
                begin
                    $display("step ended after %0d dump beats instead of %0d", beat, n_cells);
                    bad_order++;
                end
                beat       <= 0;
                steps_seen <= steps_seen + 1;
            end
            value_errors <= value_errors + bad_value;
            order_errors <= order_errors + bad_order;
        end
    end

endmodule

`default_nettype wire

// ==== lbm_lattice_top.sv ====
`include "lbm_settings.svh"

`default_nettype none

module lbm_lattice_top
    import lbm_pkg::*;
(
    input  wire logic                               clk,
    input  wire logic                               rst,
    input  wire logic                               load_valid,
    input  wire cell_t                              load_cell,
    input  wire pop_vec_t                           load_pops,
    input  wire logic [`LBM_GRID_W*`LBM_GRID_H-1:0] barriers,
    input  wire logic                               step_start,
    output logic                                    busy,
    output logic                                    dump_valid,
    output cell_t                                   dump_cell,
    output pop_vec_t                                dump_pops,
    output rho_t                                    dump_rho,
    output logic                                    step_done
);

    logic [`LBM_N_DIR-1:0][$bits(cell_t):0] rd_addr;
    logic [`LBM_N_DIR-1:0][$bits(cell_t):0] wr_addr;
    logic [`LBM_N_DIR-1:0]                  wr_en;
    pop_vec_t                               wr_data;
    pop_vec_t                               rd_data;
    logic                                   bank_cur;
    logic                                   stage_valid;
    phase_t                                 stage_phase;
    cell_t                                  stage_cell;
    logic [`LBM_N_DIR-1:0]                  stage_src_ok;
    logic [`LBM_N_DIR-1:0]                  stage_src_barrier;
    logic                                   stage_cell_barrier;

    //////////////////////////////
    // one ram per direction
    //////////////////////////////

    for (genvar d = 0; d < `LBM_N_DIR; d++)
    begin : g_dir_ram
        lattice_ram u_ram (
            .clk     (clk),
            .rd_addr (rd_addr[d]),
            .rd_data (rd_data[d]),
            .wr_en   (wr_en[d]),
            .wr_addr (wr_addr[d]),
            .wr_data (wr_data[d])
        );
    end

    // decode
    sweep_decoder u_decoder (
        .clk                (clk),
        .rst                (rst),
        .step_start         (step_start),
        .barriers           (barriers),
        .busy               (busy),
        .rd_addr            (rd_addr),
        .bank_cur           (bank_cur),
        .stage_valid        (stage_valid),
        .stage_phase        (stage_phase),
        .stage_cell         (stage_cell),
        .stage_src_ok       (stage_src_ok),
        .stage_src_barrier  (stage_src_barrier),
        .stage_cell_barrier (stage_cell_barrier)
    );

    // execute
    stream_bounce_engine u_engine (
        .clk                (clk),
        .rst                (rst),
        .load_valid         (load_valid),
        .load_cell          (load_cell),
        .load_pops          (load_pops),
        .bank_cur           (bank_cur),
        .stage_valid        (stage_valid),
        .stage_phase        (stage_phase),
        .stage_cell         (stage_cell),
        .stage_src_ok       (stage_src_ok),
        .stage_src_barrier  (stage_src_barrier),
        .stage_cell_barrier (stage_cell_barrier),
        .rd_data            (rd_data),
        .wr_en              (wr_en),
        .wr_addr            (wr_addr),
        .wr_data            (wr_data)
    );

    // result
    moment_result u_result (
        .clk         (clk),
        .rst         (rst),
        .stage_valid (stage_valid),
        .stage_phase (stage_phase),
        .stage_cell  (stage_cell),
        .rd_data     (rd_data),
        .dump_valid  (dump_valid),
        .dump_cell   (dump_cell),
        .dump_pops   (dump_pops),
        .dump_rho    (dump_rho),
        .step_done   (step_done)
    );

endmodule

`default_nettype wire

// ==== lbm_pkg.sv ====
`include "lbm_settings.svh"

`default_nettype none

package lbm_pkg;

    // row-major cell index, y * width + x
    typedef logic [$clog2(`LBM_GRID_W * `LBM_GRID_H)-1:0] cell_t;

    typedef logic [`LBM_POP_W-1:0] pop_t;
    typedef pop_t [`LBM_N_DIR-1:0] pop_vec_t;

    // nine words summed, four guard bits
    typedef logic [`LBM_POP_W+3:0] rho_t;

    typedef enum logic [3:0] {
        dir_rest, dir_n, dir_ne, dir_e, dir_se, dir_s, dir_sw, dir_w, dir_nw
    } dir_t;

    typedef enum logic [2:0] {
        phase_idle, phase_stream, phase_bounce, phase_clear, phase_dump
    } phase_t;

    //////////////////////////////
    // lattice velocities
    //////////////////////////////

    // north is y - 1, east is x + 1
    localparam int dir_dx [`LBM_N_DIR] = '{0, 0, 1, 1, 1, 0, -1, -1, -1};
    localparam int dir_dy [`LBM_N_DIR] = '{0, -1, -1, 0, 1, 1, 1, 0, -1};

    localparam dir_t dir_opp [`LBM_N_DIR] = '{
        dir_rest, dir_s, dir_sw, dir_w, dir_nw, dir_n, dir_ne, dir_e, dir_se
    };

endpackage

`default_nettype wire

// ==== lbm_properties.sv ====
`include "lbm_settings.svh"

`default_nettype none

module lbm_properties
(
    input  wire logic clk,
    input  wire logic rst,
    input  wire logic step_start,
    input  wire logic busy,
    input  wire logic dump_valid,
    input  wire logic step_done
);

    timeunit 1ns;
    timeprecision 100ps;

    localparam int n_cells = `LBM_GRID_W * `LBM_GRID_H;

    int assert_fails = 0;

    // dump beats of the running step
    int beats_q;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            beats_q <= 0;
        end
        else if (step_done)
        begin
            beats_q <= 0;
        end
        else if (dump_valid)
        begin
            beats_q <= beats_q + 1;
        end
    end

    // a new step only starts from idle
    start_when_idle: assert property (@(posedge clk) disable iff (rst) busy |-> !step_start)
    else
    begin
        $error("step_start arrived while the lattice was busy");
        assert_fails++;
    end

    dump_inside_step: assert property (@(posedge clk) disable iff (rst) dump_valid |-> busy)
    else
    begin
        $error("dump beat outside of a step");
        assert_fails++;
    end

    //////////////////////////////
    // step_done framing
    //////////////////////////////

    done_after_last: assert property (@(posedge clk) disable iff (rst)
        dump_valid && (beats_q == n_cells - 1) |=> step_done)
    else
    begin
        $error("no step_done after the last dump beat");
        assert_fails++;
    end

    done_follows_beat: assert property (@(posedge clk) disable iff (rst)
        step_done |-> $past(dump_valid) && (beats_q == n_cells))
    else
    begin
        $error("step_done without a final dump beat before it");
        assert_fails++;
    end

    done_single: assert property (@(posedge clk) disable iff (rst) step_done |=> !step_done)
    else
    begin
        $error("step_done held longer than one cycle");
        assert_fails++;
    end

    // busy drops in the step_done cycle
    done_ends_busy: assert property (@(posedge clk) disable iff (rst) step_done |-> $fell(busy))
    else
    begin
        $error("busy did not fall together with step_done");
        assert_fails++;
    end

endmodule

bind lbm_lattice_top lbm_properties props_i (
    .clk        (clk),
    .rst        (rst),
    .step_start (step_start),
    .busy       (busy),
    .dump_valid (dump_valid),
    .step_done  (step_done)
);

`default_nettype wire

// ==== lbm_settings.svh ====
`ifndef LBM_SETTINGS_SVH
`define LBM_SETTINGS_SVH

`default_nettype none

// lattice geometry
`define LBM_GRID_W 8
`define LBM_GRID_H 8

// width of one population word
`define LBM_POP_W 16

// D2Q9, rest plus eight moving directions
`define LBM_N_DIR 9

`default_nettype wire

`endif

// ==== lbm_tb.sv ====
`include "lbm_settings.svh"

`default_nettype none

module lbm_tb
    import lbm_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int n_cells = `LBM_GRID_W * `LBM_GRID_H;
    localparam int n_dir = `LBM_N_DIR;
    localparam int clk_period = 8;
    localparam int n_steps = 5;
    localparam int step_cycles = 4 * (n_cells + 2);
    // five steps, two full loads, reset and slack
    localparam int limit_cycles = n_steps * step_cycles + 2 * (n_cells + 8) + 300;

    logic               clk = 1'b0;
    logic               rst;
    logic               load_valid;
    cell_t              load_cell;
    pop_vec_t           load_pops;
    logic [n_cells-1:0] barriers;
    logic               step_start;
    logic               busy;
    logic               dump_valid;
    cell_t              dump_cell;
    pop_vec_t           dump_pops;
    rho_t               dump_rho;
    logic               step_done;

    pop_vec_t           model_state [n_cells];
    pop_vec_t           exp_state [n_cells];
    logic [n_cells-1:0] model_walls;
    logic [15:0]        lfsr;
    int                 value_errors;
    int                 order_errors;
    int                 steps_seen;
    int                 other_errors;

    always #(clk_period / 2) clk = ~clk;

    lbm_lattice_top dut_i (
        .clk        (clk),
        .rst        (rst),
        .load_valid (load_valid),
        .load_cell  (load_cell),
        .load_pops  (load_pops),
        .barriers   (barriers),
        .step_start (step_start),
        .busy       (busy),
        .dump_valid (dump_valid),
        .dump_cell  (dump_cell),
        .dump_pops  (dump_pops),
        .dump_rho   (dump_rho),
        .step_done  (step_done)
    );

    lbm_checker check_i (
        .clk          (clk),
        .rst          (rst),
        .dump_valid   (dump_valid),
        .dump_cell    (dump_cell),
        .dump_pops    (dump_pops),
        .dump_rho     (dump_rho),
        .step_done    (step_done),
        .exp_state    (exp_state),
        .value_errors (value_errors),
        .order_errors (order_errors),
        .steps_seen   (steps_seen)
    );

    //////////////////////////////
    // random source
    //////////////////////////////

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic take_bits(input int n, output logic [15:0] v);
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr = lfsr_step(lfsr);
            v = {v[14:0], lfsr[0]};
        end
    endtask

    //////////////////////////////
    // reference lattice
    //////////////////////////////

    // order rest, n, ne, e, se, s, sw, w, nw with north at y - 1
    function automatic int step_dx(input int d);
        case (d)
            2, 3, 4: return 1;
            6, 7, 8: return -1;
            default: return 0;
        endcase
    endfunction

    function automatic int step_dy(input int d);
        case (d)
            1, 2, 8: return -1;
            4, 5, 6: return 1;
            default: return 0;
        endcase
    endfunction

    function automatic int reverse_dir(input int d);
        return (d == 0) ? 0 : ((d + 3) % 8) + 1;
    endfunction

    // cell that direction d pulls from, -1 across the edge
    function automatic int source_cell(input int c, input int d);
        int sx;
        int sy;
        sx = c % `LBM_GRID_W - step_dx(d);
        sy = c / `LBM_GRID_W - step_dy(d);
        if (sx < 0 || sx >= `LBM_GRID_W || sy < 0 || sy >= `LBM_GRID_H)
            return -1;
        return sy * `LBM_GRID_W + sx;
    endfunction

    task automatic predict_step();
        pop_vec_t streamed [n_cells];
        int       src;
        for (int c = 0; c < n_cells; c++)
        begin
            for (int d = 0; d < n_dir; d++)
            begin
                src = source_cell(c, d);
                streamed[c][d] = (src < 0) ? '0 : model_state[src][d];
            end
        end
        for (int c = 0; c < n_cells; c++)
        begin
            for (int d = 0; d < n_dir; d++)
            begin
                src = source_cell(c, d);
                exp_state[c][d] = streamed[c][d];
                // wall next door sends back what reached it
                if (src >= 0 && !model_walls[c] && model_walls[src])
                    exp_state[c][d] = streamed[src][reverse_dir(d)];
                if (model_walls[c] && d != 0)
                    exp_state[c][d] = '0;
            end
        end
    endtask

    //////////////////////////////
    // stimulus
    //////////////////////////////

    task automatic load_lattice();
        logic [15:0] v;
        pop_vec_t    pops;
        for (int c = 0; c < n_cells; c++)
        begin
            for (int d = 0; d < n_dir; d++)
            begin
                take_bits(12, v);
                pops[d] = pop_t'(v);
            end
            model_state[c] = pops;
            @(posedge clk);
            load_valid <= 1'b1;
            load_cell  <= cell_t'(c);
            load_pops  <= pops;
        end
        @(posedge clk);
        load_valid <= 1'b0;
        repeat (2) @(posedge clk);
    endtask

    // about one cell in eight becomes a wall
    task automatic pick_barriers();
        logic [15:0] v;
        for (int c = 0; c < n_cells; c++)
        begin
            take_bits(3, v);
            model_walls[c] = (v[2:0] == 3'd0);
        end
        @(posedge clk);
        barriers <= model_walls;
        @(posedge clk);
    endtask

    task automatic run_step();
        int waited;
        predict_step();
        @(posedge clk);
        step_start <= 1'b1;
        @(posedge clk);
        step_start <= 1'b0;
        waited = 0;
        while (!step_done && waited < step_cycles + 16)
        begin
            @(posedge clk);
            waited++;
        end
        if (!step_done)
        begin
            $display("step did not finish within %0d cycles", step_cycles + 16);
            other_errors++;
        end
        // dumped result is the state for the next step
        for (int c = 0; c < n_cells; c++)
            model_state[c] = exp_state[c];
        @(posedge clk);
    endtask

    initial
    begin : main_flow
        rst          = 1'b1;
        load_valid   = 1'b0;
        load_cell    = '0;
        load_pops    = '0;
        barriers     = '0;
        step_start   = 1'b0;
        model_walls  = '0;
        other_errors = 0;
        lfsr         = 16'd28;
        for (int c = 0; c < n_cells; c++)
            exp_state[c] = '0;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);

        // open lattice, two steps back to back
        load_lattice();
        run_step();
        run_step();

        // walls, fresh populations, then three steps on the evolving state
        pick_barriers();
        load_lattice();
        repeat (3) run_step();

        repeat (4) @(posedge clk);
        if (steps_seen != n_steps)
        begin
            $display("saw %0d finished steps instead of %0d", steps_seen, n_steps);
            other_errors++;
        end
        $display("errors: %0d value, %0d order, %0d other, %0d assertion", value_errors,
                 order_errors, other_errors, dut_i.props_i.assert_fails);
        if (value_errors + order_errors + other_errors + dut_i.props_i.assert_fails == 0)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    end

    initial
    begin : watchdog
        #(limit_cycles * clk_period);
        $display("run stopped by the watchdog after %0d cycles", limit_cycles);
        $display("Something failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== moment_result.sv ====
`include "lbm_settings.svh"

`default_nettype none

module moment_result
    import lbm_pkg::*;
(
    input  wire logic     clk,
    input  wire logic     rst,
    input  wire logic     stage_valid,
    input  wire phase_t   stage_phase,
    input  wire cell_t    stage_cell,
    input  wire pop_vec_t rd_data,
    output logic          dump_valid,
    output cell_t         dump_cell,
    output pop_vec_t      dump_pops,
    output rho_t          dump_rho,
    output logic          step_done
);

    localparam cell_t last_cell = cell_t'(`LBM_GRID_W * `LBM_GRID_H - 1);

    rho_t rho_sum;

    // zeroth moment
    always_comb
    begin
        rho_sum = '0;
        for (int d = 0; d < `LBM_N_DIR; d++)
        begin
            rho_sum = rho_sum + rho_t'(rd_data[d]);
        end
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            dump_valid <= 1'b0;
            step_done  <= 1'b0;
        end
        else
        begin
            dump_valid <= stage_valid && (stage_phase == phase_dump);
            // one cycle behind the final beat
            step_done  <= dump_valid && (dump_cell == last_cell);
        end
    end

    always_ff @(posedge clk)
    begin
        dump_cell <= stage_cell;
        dump_pops <= rd_data;
        dump_rho  <= rho_sum;
    end

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# build the lattice testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
    -f files.f --top-module lbm_tb -o lbm_sim \
    && ./obj_dir/lbm_sim +verilator+error+limit+1000 | tee /dev/stderr \
        | grep -x "Everything OK" > /dev/null \
    && echo "PASS" \
    || { echo "FAIL"; exit 1; }

// ==== stream_bounce_engine.sv ====
`include "lbm_settings.svh"

`default_nettype none

module stream_bounce_engine
    import lbm_pkg::*;
(
    input  wire logic                               clk,
    input  wire logic                               rst,
    input  wire logic                               load_valid,
    input  wire cell_t                              load_cell,
    input  wire pop_vec_t                           load_pops,
    input  wire logic                               bank_cur,
    input  wire logic                               stage_valid,
    input  wire phase_t                             stage_phase,
    input  wire cell_t                              stage_cell,
    input  wire logic [`LBM_N_DIR-1:0]              stage_src_ok,
    input  wire logic [`LBM_N_DIR-1:0]              stage_src_barrier,
    input  wire logic                               stage_cell_barrier,
    input  wire pop_vec_t                           rd_data,
    output logic [`LBM_N_DIR-1:0]                   wr_en,
    output logic [`LBM_N_DIR-1:0][$bits(cell_t):0]  wr_addr,
    output pop_vec_t                                wr_data
);

    logic     load_q_valid;
    cell_t    load_q_cell;
    pop_vec_t load_q_pops;
    logic     load_win;

    //////////////////////////////
    // load capture
    //////////////////////////////

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            load_q_valid <= 1'b0;
        end
        else
        begin
            load_q_valid <= load_valid;
        end
    end

    always_ff @(posedge clk)
    begin
        load_q_cell <= load_cell;
        load_q_pops <= load_pops;
    end

    // loads only land while the sweep is idle
    assign load_win = load_q_valid && (stage_phase == phase_idle);

    //////////////////////////////
    // write port per direction
    //////////////////////////////

    always_comb
    begin
        for (int d = 0; d < `LBM_N_DIR; d++)
        begin
            wr_en[d]   = 1'b0;
            wr_addr[d] = {~bank_cur, stage_cell};
            wr_data[d] = '0;
            if (load_win)
            begin
                // initial state goes to the current bank
                wr_en[d]   = 1'b1;
                wr_addr[d] = {bank_cur, load_q_cell};
                wr_data[d] = load_q_pops[d];
            end
            else if (stage_valid)
            begin
                unique case (stage_phase)
                    phase_stream:
                    begin
                        // nothing flows in across the grid edge
                        wr_en[d]   = 1'b1;
                        wr_data[d] = stage_src_ok[d] ? rd_data[d] : '0;
                    end
                    phase_bounce:
                    begin
                        // fluid cell fed from a wall, take what hit the wall
                        wr_en[d]   = stage_src_ok[d] && stage_src_barrier[d]
                                     && !stage_cell_barrier;
                        wr_data[d] = rd_data[dir_opp[d]];
                    end
                    phase_clear:
                    begin
                        // rest population stays
                        wr_en[d]   = stage_cell_barrier && (d != int'(dir_rest));
                        wr_data[d] = '0;
                    end
                    default:
                    begin
                        wr_en[d] = 1'b0;
                    end
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// ==== sweep_decoder.sv ====
`include "lbm_settings.svh"

`default_nettype none

module sweep_decoder
    import lbm_pkg::*;
(
    input  wire logic                                   clk,
    input  wire logic                                   rst,
    input  wire logic                                   step_start,
    input  wire logic [`LBM_GRID_W*`LBM_GRID_H-1:0]     barriers,
    output logic                                        busy,
    output logic [`LBM_N_DIR-1:0][$bits(cell_t):0]      rd_addr,
    output logic                                        bank_cur,
    output logic                                        stage_valid,
    output phase_t                                      stage_phase,
    output cell_t                                       stage_cell,
    output logic [`LBM_N_DIR-1:0]                       stage_src_ok,
    output logic [`LBM_N_DIR-1:0]                       stage_src_barrier,
    output logic                                        stage_cell_barrier
);

    localparam int x_w = $clog2(`LBM_GRID_W);
    localparam int y_w = $clog2(`LBM_GRID_H);

    phase_t          phase_q;
    logic [x_w-1:0]  x_q;
    logic [y_w-1:0]  y_q;
    logic            drain_q;
    logic            tail_q;
    logic            issue;
    cell_t           cur_cell;
    cell_t           src_cell [`LBM_N_DIR];
    logic [`LBM_N_DIR-1:0] src_ok;

    // tail keeps busy up while the last dump beat leaves the result stage
    assign busy = (phase_q != phase_idle) || tail_q;
    assign issue = (phase_q != phase_idle) && !drain_q;

    //////////////////////////////
    // phase sequencer and sweep
    //////////////////////////////

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            phase_q  <= phase_idle;
            x_q      <= '0;
            y_q      <= '0;
            drain_q  <= 1'b0;
            tail_q   <= 1'b0;
            bank_cur <= 1'b0;
        end
        else
        begin
            tail_q <= 1'b0;
            if (phase_q == phase_idle)
            begin
                if (step_start && !busy)
                begin
                    phase_q <= phase_stream;
                end
            end
            else if (drain_q)
            begin
                drain_q <= 1'b0;
                unique case (phase_q)
                    phase_stream: phase_q <= phase_bounce;
                    phase_bounce: phase_q <= phase_clear;
                    phase_clear:  phase_q <= phase_dump;
                    default:
                    begin
                        // result written, next bank becomes current
                        phase_q  <= phase_idle;
                        bank_cur <= ~bank_cur;
                        tail_q   <= 1'b1;
                    end
                endcase
            end
            else if (x_q == x_w'(`LBM_GRID_W - 1))
            begin
                x_q <= '0;
                if (y_q == y_w'(`LBM_GRID_H - 1))
                begin
                    y_q     <= '0;
                    drain_q <= 1'b1;
                end
                else
                begin
                    y_q <= y_q + 1'b1;
                end
            end
            else
            begin
                x_q <= x_q + 1'b1;
            end
        end
    end

    // pull source of every direction, clamped to the cell itself off grid
    always_comb
    begin : src_calc
        int sx;
        int sy;
        cur_cell = cell_t'(int'(y_q) * `LBM_GRID_W + int'(x_q));
        for (int d = 0; d < `LBM_N_DIR; d++)
        begin
            sx = int'(x_q) - dir_dx[d];
            sy = int'(y_q) - dir_dy[d];
            src_ok[d] = (sx >= 0) && (sx < `LBM_GRID_W) && (sy >= 0) && (sy < `LBM_GRID_H);
            src_cell[d] = src_ok[d] ? cell_t'(sy * `LBM_GRID_W + sx) : cur_cell;
        end
    end

    //////////////////////////////
    // read addresses
    //////////////////////////////

    always_comb
    begin
        for (int d = 0; d < `LBM_N_DIR; d++)
        begin
            unique case (phase_q)
                phase_stream: rd_addr[d] = {bank_cur, src_cell[d]};
                // barrier value travelling back along d sits in ram opp(d)
                phase_bounce: rd_addr[d] = {~bank_cur, src_cell[dir_opp[d]]};
                // clear ignores the data
                default:      rd_addr[d] = {~bank_cur, cur_cell};
            endcase
        end
    end

    // stage signals, aligned with the ram data
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            stage_valid <= 1'b0;
            stage_phase <= phase_idle;
        end
        else
        begin
            stage_valid <= issue;
            stage_phase <= phase_q;
        end
    end

    always_ff @(posedge clk)
    begin
        stage_cell         <= cur_cell;
        stage_src_ok       <= src_ok;
        stage_cell_barrier <= barriers[cur_cell];
        for (int d = 0; d < `LBM_N_DIR; d++)
        begin
            stage_src_barrier[d] <= src_ok[d] && barriers[src_cell[d]];
        end
    end

endmodule

`default_nettype wire
